// File: hw/slurm16_pkg.sv
// Shared widths, instruction classes, ALU and branch encodings, instruction union, stage structs.
`default_nettype none

package slurm16_pkg;

	localparam int BITS = 16;
	localparam int ADDRESS_BITS = 16;

	typedef logic [3:0] reg_sel_t;

	// **************************************************
	// Instruction encodings.
	// **************************************************

	typedef enum logic [3:0] {
		CLS_MISC      = 4'd0,	// 11:8 pick nop, sleep, int off, int on.
		CLS_ALU_RR    = 4'd1,
		CLS_ALU_RI    = 4'd2,
		CLS_ALU_R     = 4'd3,	// Operand B is zero.
		CLS_BRANCH    = 4'd4,
		CLS_RET       = 4'd5,	// Bit 0 marks iret.
		CLS_INT       = 4'd6,	// Vector in 3:0.
		CLS_PORT      = 4'd7,	// Bit 11 marks poke.
		CLS_LDST      = 4'd8,	// Bit 11 marks store.
		CLS_LDST_BYTE = 4'd9
	} ins_class_t;

	typedef enum logic [3:0] {
		ALU_MOV, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_CMP, ALU_TST, ALU_SHL, ALU_SHR
	} alu_op_t;

	typedef enum logic [3:0] {
		BR_ALWAYS, BR_Z, BR_NZ, BR_C, BR_NC, BR_S, BR_NS
	} branch_cond_t;

	typedef struct packed {
		ins_class_t cls;
		alu_op_t    op;
		reg_sel_t   dest;
		reg_sel_t   src;
	} alu_fmt_t;

	typedef struct packed {
		ins_class_t cls;
		logic [3:0] dir_or_cond;	// Direction or branch condition.
		reg_sel_t   dest;
		logic [3:0] aux;
	} mem_fmt_t;

	// Same word, read as ALU or memory/branch format.
	typedef union packed {
		alu_fmt_t alu_fmt;
		mem_fmt_t mem_fmt;
	} ins_word_t;

	// **************************************************
	// Transfers between blocks.
	// **************************************************

	typedef struct packed {
		alu_op_t           op;
		logic [BITS-1:0]   a;
		logic [BITS-1:0]   b;
		reg_sel_t          dest;
		logic              we;
	} alu_req_t;

	typedef struct packed {
		logic                    valid;
		logic                    store;
		logic                    is_port;
		logic [ADDRESS_BITS-1:0] address;
		logic [BITS-1:0]         wdata;
		logic [1:0]              mask;
		reg_sel_t                dest;
	} bus_req_t;

	typedef struct packed {
		logic            valid;
		reg_sel_t        dest;
		logic [BITS-1:0] data;
	} wb_t;

	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [ADDRESS_BITS-1:0] paddr;
		logic [BITS-1:0]         pwdata;
		logic [1:0]              pstrb;
	} apb_m_t;

	typedef struct packed {
		logic [BITS-1:0] prdata;
		logic            pready;
	} apb_s_t;

endpackage

`default_nettype wire

// File: hw/slurm16_execute.sv
// Execute stage: slot decode, ALU request register, branch, bus, interrupt-flag and halt requests.
`timescale 1ns/1ps
`default_nettype none

module slurm16_execute #(
	parameter int BITS = slurm16_pkg::BITS,
	parameter int ADDRESS_BITS = slurm16_pkg::ADDRESS_BITS
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    ins_valid,
	input  logic                    ins_ready,
	input  slurm16_pkg::ins_word_t  instruction,
	input  logic [BITS-1:0]         reg_a,
	input  logic [BITS-1:0]         reg_b,
	input  logic [BITS-1:0]         imm_reg,
	input  logic                    z,
	input  logic                    c,
	input  logic                    s,
	output slurm16_pkg::alu_req_t   alu_req,
	output slurm16_pkg::bus_req_t   bus_req,
	output logic                    load_pc,
	output logic [ADDRESS_BITS-1:0] new_pc,
	output logic                    int_flag_set,
	output logic                    int_flag_clear,
	output logic                    halt
);
	import slurm16_pkg::*;

	logic                    accept;
	ins_class_t              cls;
	logic [ADDRESS_BITS-1:0] ls_addr;
	alu_op_t                 op_next;
	logic                    we_next;
	logic [BITS-1:0]         b_next;
	logic                    taken;

	assign accept = ins_valid & ins_ready;
	assign cls = instruction.alu_fmt.cls;
	assign ls_addr = ADDRESS_BITS'(reg_b + imm_reg);	// Memory and port address.

	// **************************************************
	// ALU request.
	// **************************************************

	always_comb begin
		op_next = ALU_MOV;
		we_next = 1'b0;
		b_next = reg_b;
		if (cls inside {CLS_ALU_RR, CLS_ALU_RI, CLS_ALU_R}) begin
			op_next = instruction.alu_fmt.op;
			we_next = !(instruction.alu_fmt.op inside {ALU_CMP, ALU_TST});
		end
		if (cls == CLS_ALU_RI)
			b_next = imm_reg;
		else if (cls == CLS_ALU_R)
			b_next = '0;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			alu_req.op <= ALU_MOV;
			alu_req.we <= 1'b0;
		end else begin
			// Idle cycles fall back to a mov that neither writes nor touches flags.
			alu_req.op <= accept ? op_next : ALU_MOV;
			alu_req.we <= accept & we_next;
		end
		if (accept) begin
			alu_req.a <= reg_a;
			alu_req.b <= b_next;
			alu_req.dest <= instruction.alu_fmt.dest;
		end
	end

	// **************************************************
	// Branch, interrupt and halt.
	// **************************************************

	always_comb begin
		case (branch_cond_t'(instruction.mem_fmt.dir_or_cond))
			BR_ALWAYS: taken = 1'b1;
			BR_Z:      taken = z;
			BR_NZ:     taken = !z;
			BR_C:      taken = c;
			BR_NC:     taken = !c;
			BR_S:      taken = s;
			BR_NS:     taken = !s;
			default:   taken = 1'b0;
		endcase
	end

	always_comb begin
		load_pc = 1'b0;
		new_pc = '0;
		int_flag_set = 1'b0;
		int_flag_clear = 1'b0;
		halt = 1'b0;
		if (accept) begin
			case (cls)
				CLS_MISC: begin
					case (instruction.mem_fmt.dir_or_cond)
						4'd1: halt = 1'b1;		// Sleep.
						4'd2: int_flag_clear = 1'b1;
						4'd3: int_flag_set = 1'b1;
						default: ;
					endcase
				end
				CLS_BRANCH: begin
					load_pc = taken;
					new_pc = ADDRESS_BITS'(reg_a + imm_reg);
				end
				CLS_RET: begin
					load_pc = 1'b1;
					new_pc = ADDRESS_BITS'(reg_a);
					int_flag_set = instruction.mem_fmt.aux[0];	// Iret re-enables.
				end
				CLS_INT: begin
					load_pc = 1'b1;
					new_pc = ADDRESS_BITS'({instruction.mem_fmt.aux, 2'b00});
				end
				default: ;
			endcase
		end
	end

	// Load, store, peek and poke requests.
	always_comb begin
		bus_req = '0;
		bus_req.store = instruction.mem_fmt.dir_or_cond[3];
		bus_req.address = ls_addr;
		bus_req.wdata = reg_a;
		bus_req.mask = 2'b11;
		bus_req.dest = instruction.mem_fmt.dest;
		case (cls)
			CLS_PORT: begin
				bus_req.valid = accept;
				bus_req.is_port = 1'b1;
			end
			CLS_LDST: bus_req.valid = accept;
			CLS_LDST_BYTE: begin
				bus_req.valid = accept;
				bus_req.mask = ls_addr[0] ? 2'b10 : 2'b01;
				if (ls_addr[0])
					bus_req.wdata = reg_a << 8;	// Odd byte goes to the high lane.
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/slurm16_alu.sv
// ALU datapath with result output and Z, C, S flag register.
`timescale 1ns/1ps
`default_nettype none

module slurm16_alu #(
	parameter int BITS = slurm16_pkg::BITS
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  slurm16_pkg::alu_req_t alu_req,
	output slurm16_pkg::wb_t      result,
	output logic                  z,
	output logic                  c,
	output logic                  s
);
	import slurm16_pkg::*;

	logic [BITS:0] wide;	// Carry on top.
	logic          flag_upd;

	always_comb begin
		case (alu_req.op)
			ALU_ADD: wide = {1'b0, alu_req.a} + {1'b0, alu_req.b};
			ALU_ADC: wide = {1'b0, alu_req.a} + {1'b0, alu_req.b} + {{BITS{1'b0}}, c};
			ALU_SUB, ALU_CMP: wide = {1'b0, alu_req.a} - {1'b0, alu_req.b};
			ALU_SBB: wide = {1'b0, alu_req.a} - {1'b0, alu_req.b} - {{BITS{1'b0}}, c};
			ALU_AND, ALU_TST: wide = {c, alu_req.a & alu_req.b};
			ALU_OR:  wide = {c, alu_req.a | alu_req.b};
			ALU_XOR: wide = {c, alu_req.a ^ alu_req.b};
			ALU_SHL: wide = {alu_req.a, 1'b0};
			ALU_SHR: wide = {alu_req.a[0], 1'b0, alu_req.a[BITS-1:1]};
			default: wide = {c, alu_req.b};		// Mov and spare codes.
		endcase
	end

	assign flag_upd = alu_req.we | (alu_req.op inside {ALU_CMP, ALU_TST});

	assign result.valid = alu_req.we;
	assign result.dest = alu_req.dest;
	assign result.data = wide[BITS-1:0];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			z <= 1'b0;
			c <= 1'b0;
			s <= 1'b0;
		end else if (flag_upd) begin
			z <= (wide[BITS-1:0] == '0);
			c <= wide[BITS];
			s <= wide[BITS-1];
		end
	end

	// Idle and non-ALU slots arrive as a non-writing mov, so flags stay put.
	a_idle_is_mov: assert property (@(posedge CLK) disable iff (!RSTb)
		!alu_req.we |-> (alu_req.op inside {ALU_MOV, ALU_CMP, ALU_TST}))
		else $error("Non-writing ALU request with an op other than mov, cmp or tst.");

endmodule

`default_nettype wire

// File: hw/slurm16_bus_bridge.sv
// APB master bridge: IDLE/SETUP/ACCESS FSM, port offset, byte lane select on loads.
`timescale 1ns/1ps
`default_nettype none

module slurm16_bus_bridge #(
	parameter int BITS = slurm16_pkg::BITS,
	parameter int ADDRESS_BITS = slurm16_pkg::ADDRESS_BITS
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  slurm16_pkg::bus_req_t bus_req,
	input  slurm16_pkg::apb_s_t   apb_in,
	output slurm16_pkg::apb_m_t   apb_out,
	output logic                  busy,
	output slurm16_pkg::wb_t      result
);
	import slurm16_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} state_t;

	// Port space sits above the top address bit.
	localparam logic [ADDRESS_BITS-1:0] PORT_BASE = {1'b1, {(ADDRESS_BITS-1){1'b0}}};

	state_t          state;
	bus_req_t        req;
	logic            done;
	logic [BITS-1:0] rd_data;

	assign done = (state == ST_ACCESS) && apb_in.pready;
	assign busy = (state != ST_IDLE);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (bus_req.valid) state <= ST_SETUP;
				ST_SETUP:  state <= ST_ACCESS;
				ST_ACCESS: if (apb_in.pready) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
		if (state == ST_IDLE && bus_req.valid)
			req <= bus_req;
	end

	always_comb begin
		apb_out.psel = busy;
		apb_out.penable = (state == ST_ACCESS);
		apb_out.pwrite = req.store;
		apb_out.paddr = req.is_port ? req.address + PORT_BASE : req.address;
		apb_out.pwdata = req.wdata;
		apb_out.pstrb = req.store ? req.mask : 2'b00;
	end

	// Byte loads come back zero-extended.
	always_comb begin
		case (req.mask)
			2'b01:   rd_data = BITS'(apb_in.prdata[7:0]);
			2'b10:   rd_data = BITS'(apb_in.prdata[15:8]);
			default: rd_data = apb_in.prdata;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			result.valid <= 1'b0;
		else
			result.valid <= done & !req.store;
		result.dest <= req.dest;
		result.data <= rd_data;
	end

	a_paddr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == ST_ACCESS) |-> $stable(apb_out.paddr))
		else $error("PADDR moved during ACCESS.");

endmodule

`default_nettype wire

// File: hw/slurm16_writeback.sv
// Writeback merger: one registered register write from ALU or load results.
`timescale 1ns/1ps
`default_nettype none

module slurm16_writeback (
	input  logic             CLK,
	input  logic             RSTb,
	input  slurm16_pkg::wb_t alu_res,
	input  slurm16_pkg::wb_t bus_res,
	output slurm16_pkg::wb_t wb
);
	import slurm16_pkg::*;

	wb_t sel;

	assign sel = bus_res.valid ? bus_res : alu_res;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			wb.valid <= 1'b0;
		else
			wb.valid <= sel.valid;
		wb.dest <= sel.dest;
		wb.data <= sel.data;
	end

	// The stage stalls during a load, so an ALU result cannot land with it.
	a_single_source: assert property (@(posedge CLK) disable iff (!RSTb)
		!(alu_res.valid && bus_res.valid))
		else $error("ALU and load results collided at writeback.");

endmodule

`default_nettype wire

// File: hw/slurm16_exec_top.sv
// Execute stage top: stage decode, ALU, APB bridge and writeback merger.
`timescale 1ns/1ps
`default_nettype none

module slurm16_exec_top #(
	parameter int BITS = slurm16_pkg::BITS,
	parameter int ADDRESS_BITS = slurm16_pkg::ADDRESS_BITS
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    ins_valid,
	output logic                    ins_ready,
	input  slurm16_pkg::ins_word_t  instruction,
	input  logic [BITS-1:0]         reg_a,
	input  logic [BITS-1:0]         reg_b,
	input  logic [BITS-1:0]         imm_reg,
	output slurm16_pkg::apb_m_t     apb_out,
	input  slurm16_pkg::apb_s_t     apb_in,
	output slurm16_pkg::wb_t        wb,
	output logic                    load_pc,
	output logic [ADDRESS_BITS-1:0] new_pc,
	output logic                    int_flag_set,
	output logic                    int_flag_clear,
	output logic                    halt
);
	import slurm16_pkg::*;

	alu_req_t alu_req;
	bus_req_t bus_req;
	wb_t      alu_res;
	wb_t      bus_res;
	logic     z, c, s;
	logic     busy;

	assign ins_ready = !busy;	// Stall while a transfer is open.

	slurm16_execute #(.BITS(BITS), .ADDRESS_BITS(ADDRESS_BITS)) u_execute (
		.CLK, .RSTb, .ins_valid, .ins_ready, .instruction, .reg_a, .reg_b, .imm_reg,
		.z, .c, .s, .alu_req, .bus_req, .load_pc, .new_pc,
		.int_flag_set, .int_flag_clear, .halt
	);

	slurm16_alu #(.BITS(BITS)) u_alu (
		.CLK, .RSTb, .alu_req, .result(alu_res), .z, .c, .s
	);

	slurm16_bus_bridge #(.BITS(BITS), .ADDRESS_BITS(ADDRESS_BITS)) u_bridge (
		.CLK, .RSTb, .bus_req, .apb_in, .apb_out, .busy, .result(bus_res)
	);

	slurm16_writeback u_writeback (
		.CLK, .RSTb, .alu_res, .bus_res, .wb
	);

endmodule

`default_nettype wire

// File: test/tb_slurm16_exec.sv
// Testbench for the execute stage top: clock, APB memory model, stimulus table, checks, watchdog.
`timescale 1ns/1ps
`default_nettype none

module tb_slurm16_exec;
	import slurm16_pkg::*;

	typedef struct {
		string       name;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm;
		logic        exp_we;
		logic [3:0]  exp_dest;
		logic [15:0] exp_data;
		logic        exp_load_pc;
		logic [15:0] exp_pc;
		logic [2:0]  exp_ctl;		// Int set, int clear, halt.
		logic [2:0]  exp_flags;		// Z, C, S.
		logic [1:0]  exp_strb;		// Zero when no APB write is due.
		logic [15:0] exp_paddr;
	} row_t;

	logic        CLK = 1'b0;
	logic        RSTb;
	logic        ins_valid;
	logic        ins_ready;
	ins_word_t   instruction;
	logic [15:0] reg_a;
	logic [15:0] reg_b;
	logic [15:0] imm_reg;
	apb_m_t      apb_out;
	apb_s_t      apb_in = '0;
	wb_t         wb;
	logic        load_pc;
	logic [15:0] new_pc;
	logic        int_flag_set;
	logic        int_flag_clear;
	logic        halt;

	row_t        rows[$];
	logic        table_built = 1'b0;
	int          checks = 0;
	int          errors = 0;
	int          seed = 97;
	int          write_count = 0;
	logic [1:0]  last_strb;
	logic [15:0] last_paddr;
	logic [15:0] mem [0:255];
	logic [15:0] ports [0:15];

	always #10 CLK = ~CLK;

	slurm16_exec_top #(.BITS(16), .ADDRESS_BITS(16)) dut (
		.CLK, .RSTb, .ins_valid, .ins_ready, .instruction, .reg_a, .reg_b, .imm_reg,
		.apb_out, .apb_in, .wb, .load_pc, .new_pc, .int_flag_set, .int_flag_clear, .halt
	);

	// **************************************************
	// APB memory model with random wait states.
	// **************************************************

	function automatic logic [15:0] read_word(input logic [15:0] addr);
		if (addr[15])
			return ports[addr[4:1]];	// Port space.
		return mem[addr[8:1]];
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
			input logic [1:0] strb);
		return {strb[1] ? data[15:8] : old[15:8], strb[0] ? data[7:0] : old[7:0]};
	endfunction

	always @(negedge CLK) begin
		int rnd;
		rnd = $random(seed);
		apb_in.pready = apb_out.psel && apb_out.penable && rnd[0];
		apb_in.prdata = apb_out.psel ? read_word(apb_out.paddr) : 16'h0;
	end

	always @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 256; i++)
				mem[i] = {~8'(i), 8'(i)};	// Pattern from the word index.
			for (int i = 0; i < 16; i++)
				ports[i] = 16'h0;
		end else if (apb_out.psel && apb_out.penable && apb_in.pready && apb_out.pwrite) begin
			if (apb_out.paddr[15])
				ports[apb_out.paddr[4:1]] = merge_bytes(ports[apb_out.paddr[4:1]],
					apb_out.pwdata, apb_out.pstrb);
			else
				mem[apb_out.paddr[8:1]] = merge_bytes(mem[apb_out.paddr[8:1]],
					apb_out.pwdata, apb_out.pstrb);
			last_strb = apb_out.pstrb;
			last_paddr = apb_out.paddr;
			write_count++;
		end
	end

	// **************************************************
	// Checks and table helpers.
	// **************************************************

	task automatic check_value(input string name, input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	function automatic logic [15:0] alu_word(input logic [3:0] cls, input logic [3:0] op,
			input logic [3:0] dest);
		return {cls, op, dest, 4'h0};
	endfunction

	function automatic logic [15:0] mem_word(input logic [3:0] cls, input logic [3:0] dir,
			input logic [3:0] dest, input logic [3:0] aux);
		return {cls, dir, dest, aux};
	endfunction

	task automatic add_row(input string name, input logic [15:0] ins, a, b, imm,
			input logic exp_we, input logic [3:0] exp_dest, input logic [15:0] exp_data,
			input logic exp_load_pc, input logic [15:0] exp_pc, input logic [2:0] exp_ctl,
			input logic [2:0] exp_flags, input logic [1:0] exp_strb,
			input logic [15:0] exp_paddr);
		row_t r;
		r.name = name;
		r.ins = ins;
		r.a = a;
		r.b = b;
		r.imm = imm;
		r.exp_we = exp_we;
		r.exp_dest = exp_dest;
		r.exp_data = exp_data;
		r.exp_load_pc = exp_load_pc;
		r.exp_pc = exp_pc;
		r.exp_ctl = exp_ctl;
		r.exp_flags = exp_flags;
		r.exp_strb = exp_strb;
		r.exp_paddr = exp_paddr;
		rows.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		int writes_before;
		writes_before = write_count;
		while (!ins_ready)
			@(negedge CLK);
		ins_valid = 1'b1;
		instruction = r.ins;
		reg_a = r.a;
		reg_b = r.b;
		imm_reg = r.imm;
		#5;	// Acceptance cycle outputs.
		check_value(r.name, "load_pc", r.exp_load_pc, load_pc);
		if (r.exp_load_pc)
			check_value(r.name, "new_pc", r.exp_pc, new_pc);
		check_value(r.name, "set/clear/halt", r.exp_ctl, {int_flag_set, int_flag_clear, halt});
		@(posedge CLK);
		@(negedge CLK);
		ins_valid = 1'b0;
		check_value(r.name, "early wb_valid", 1'b0, wb.valid);
		while (!ins_ready)
			@(negedge CLK);
		@(negedge CLK);
		check_value(r.name, "wb_valid", r.exp_we, wb.valid);
		if (r.exp_we) begin
			check_value(r.name, "wb_dest", r.exp_dest, wb.dest);
			check_value(r.name, "wb_data", r.exp_data, wb.data);
		end
		check_value(r.name, "flags zcs", r.exp_flags, {dut.z, dut.c, dut.s});
		check_value(r.name, "apb writes", writes_before + (r.exp_strb != 2'b00), write_count);
		if (r.exp_strb != 2'b00) begin
			check_value(r.name, "pstrb", r.exp_strb, last_strb);
			check_value(r.name, "paddr", r.exp_paddr, last_paddr);
		end
		@(negedge CLK);
		check_value(r.name, "wb_valid pulse", 1'b0, wb.valid);	// One cycle only.
	endtask

	// **************************************************
	// Stimulus table.
	// **************************************************

	task automatic build_table();
		add_row("add_rr", alu_word(CLS_ALU_RR, ALU_ADD, 4'd1), 16'h1234, 16'h0101, 16'h0,
			1'b1, 4'd1, 16'h1335, 1'b0, 16'h0, 3'b000, 3'b000, 2'b00, 16'h0);
		add_row("add_carry", alu_word(CLS_ALU_RR, ALU_ADD, 4'd2), 16'hFFFF, 16'h0002, 16'h0,
			1'b1, 4'd2, 16'h0001, 1'b0, 16'h0, 3'b000, 3'b010, 2'b00, 16'h0);
		add_row("adc", alu_word(CLS_ALU_RR, ALU_ADC, 4'd3), 16'h0010, 16'h0020, 16'h0,
			1'b1, 4'd3, 16'h0031, 1'b0, 16'h0, 3'b000, 3'b000, 2'b00, 16'h0);
		add_row("sub_borrow", alu_word(CLS_ALU_RR, ALU_SUB, 4'd4), 16'h0005, 16'h0007, 16'h0,
			1'b1, 4'd4, 16'hFFFE, 1'b0, 16'h0, 3'b000, 3'b011, 2'b00, 16'h0);
		add_row("sbb_ri", alu_word(CLS_ALU_RI, ALU_SBB, 4'd5), 16'h0100, 16'h7777, 16'h0001,
			1'b1, 4'd5, 16'h00FE, 1'b0, 16'h0, 3'b000, 3'b000, 2'b00, 16'h0);
		add_row("cmp_eq", alu_word(CLS_ALU_RR, ALU_CMP, 4'd6), 16'h0042, 16'h0042, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b100, 2'b00, 16'h0);
		add_row("br_z_taken", mem_word(CLS_BRANCH, BR_Z, 4'd0, 4'd0), 16'h0100, 16'h0, 16'h0020,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0120, 3'b000, 3'b100, 2'b00, 16'h0);
		add_row("br_nz_not", mem_word(CLS_BRANCH, BR_NZ, 4'd0, 4'd0), 16'h0100, 16'h0, 16'h0020,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b100, 2'b00, 16'h0);
		add_row("shl_r", alu_word(CLS_ALU_R, ALU_SHL, 4'd7), 16'h8001, 16'hFFFF, 16'h0,
			1'b1, 4'd7, 16'h0002, 1'b0, 16'h0, 3'b000, 3'b010, 2'b00, 16'h0);
		add_row("or_r", alu_word(CLS_ALU_R, ALU_OR, 4'd8), 16'h8421, 16'h1111, 16'h0,
			1'b1, 4'd8, 16'h8421, 1'b0, 16'h0, 3'b000, 3'b011, 2'b00, 16'h0);
		add_row("br_s_taken", mem_word(CLS_BRANCH, BR_S, 4'd0, 4'd0), 16'h0200, 16'h0, 16'h0004,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0204, 3'b000, 3'b011, 2'b00, 16'h0);
		add_row("br_nc_not", mem_word(CLS_BRANCH, BR_NC, 4'd0, 4'd0), 16'h0200, 16'h0, 16'h0004,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b011, 2'b00, 16'h0);
		add_row("tst_zero", alu_word(CLS_ALU_RR, ALU_TST, 4'd9), 16'h00F0, 16'h0F00, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("br_c_taken", mem_word(CLS_BRANCH, BR_C, 4'd0, 4'd0), 16'h0300, 16'h0, 16'h0010,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0310, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("ret", mem_word(CLS_RET, 4'd0, 4'd0, 4'd0), 16'h0345, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0345, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("iret", mem_word(CLS_RET, 4'd0, 4'd0, 4'd1), 16'h0400, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0400, 3'b100, 3'b110, 2'b00, 16'h0);
		add_row("int5", mem_word(CLS_INT, 4'd0, 4'd0, 4'd5), 16'h0, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b1, 16'h0014, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("int_off", mem_word(CLS_MISC, 4'd2, 4'd0, 4'd0), 16'h0, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b010, 3'b110, 2'b00, 16'h0);
		add_row("int_on", mem_word(CLS_MISC, 4'd3, 4'd0, 4'd0), 16'h0, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b100, 3'b110, 2'b00, 16'h0);
		add_row("sleep", mem_word(CLS_MISC, 4'd1, 4'd0, 4'd0), 16'h0, 16'h0, 16'h0,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b001, 3'b110, 2'b00, 16'h0);
		add_row("st_word", mem_word(CLS_LDST, 4'h8, 4'd0, 4'd0), 16'h1234, 16'h0040, 16'h0006,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b110, 2'b11, 16'h0046);
		add_row("ld_word", mem_word(CLS_LDST, 4'h0, 4'd10, 4'd0), 16'h0, 16'h0040, 16'h0006,
			1'b1, 4'd10, 16'h1234, 1'b0, 16'h0, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("st_byte_odd", mem_word(CLS_LDST_BYTE, 4'h8, 4'd0, 4'd0), 16'h005C, 16'h0020,
			16'h0001, 1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b110, 2'b10, 16'h0021);
		add_row("ld_after_byte", mem_word(CLS_LDST, 4'h0, 4'd11, 4'd0), 16'h0, 16'h0020, 16'h0,
			1'b1, 4'd11, 16'h5C10, 1'b0, 16'h0, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("ld_byte_odd", mem_word(CLS_LDST_BYTE, 4'h0, 4'd12, 4'd0), 16'h0, 16'h0020,
			16'h0001, 1'b1, 4'd12, 16'h005C, 1'b0, 16'h0, 3'b000, 3'b110, 2'b00, 16'h0);
		add_row("poke", mem_word(CLS_PORT, 4'h8, 4'd0, 4'd0), 16'hBEEF, 16'h0004, 16'h0002,
			1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 3'b000, 3'b110, 2'b11, 16'h8006);
		add_row("peek", mem_word(CLS_PORT, 4'h0, 4'd13, 4'd0), 16'h0, 16'h0004, 16'h0002,
			1'b1, 4'd13, 16'hBEEF, 1'b0, 16'h0, 3'b000, 3'b110, 2'b00, 16'h0);
	endtask

	initial begin
		RSTb = 1'b0;
		ins_valid = 1'b0;
		instruction = '0;
		reg_a = 16'h0;
		reg_b = 16'h0;
		imm_reg = 16'h0;
		build_table();
		table_built = 1'b1;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		// Psel, penable, wb_valid, load_pc, halt, set, clear low; ins_ready high.
		check_value("reset", "idle outputs", 8'b0000_0001, {apb_out.psel, apb_out.penable,
			wb.valid, load_pc, halt, int_flag_set, int_flag_clear, ins_ready});
		RSTb = 1'b1;
		foreach (rows[i])
			apply_row(rows[i]);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog scaled by table length.
	initial begin
		wait (table_built);
		repeat (8 + rows.size() * 40) @(posedge CLK);
		$display("Timeout: the stimulus table did not finish within %0d cycles.",
			rows.size() * 40);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hw/slurm16_pkg.sv
hw/slurm16_execute.sv
hw/slurm16_alu.sv
hw/slurm16_bus_bridge.sv
hw/slurm16_writeback.sv
hw/slurm16_exec_top.sv
test/tb_slurm16_exec.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_slurm16_exec
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
